// ==== source/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	//////////////////////////////////////////////////////////////////////
	// Instruction word views
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rd;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] shamt;
		logic [5:0] fn;
	} rForm_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic [15:0] imm;
	} iForm_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] target;
	} jForm_t;

	// Same 32 bits, decoded per instruction form
	typedef union packed {
		rForm_t r;
		iForm_t i;
		jForm_t j;
	} instrWord_t;

	//////////////////////////////////////////////////////////////////////
	// Control word
	//////////////////////////////////////////////////////////////////////

	typedef enum logic {destRd = 1'b0, destLink = 1'b1} regDst_e;

	typedef enum logic [1:0] {fromMem, fromAlu, fromLink, fromShift} regInData_e;

	typedef enum logic [1:0] {pcNext, pcJump, pcBranch, pcReg} pcSel_e;

	typedef struct packed {
		regDst_e    regDst;
		logic       writeEn;
		logic       aluImm;
		logic       aluFn;
		logic       logicFn;
		logic       fnClass;
		logic       regImm;
		logic       shiftLogical;
		logic       shiftLeft;
		logic       dataRead;
		logic       dataWrite;
		// Bits 1:0 pick the test on rs, bit 2 inverts it
		logic [2:0] brType;
		pcSel_e     pcSel;
		regInData_e regInData;
	} ctrlWord_t;

	//////////////////////////////////////////////////////////////////////
	// Result records
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic        writeEn;
		logic [4:0]  writeReg;
		logic [31:0] writeData;
	} regWrite_t;

	typedef struct packed {
		logic        memRead;
		logic        memWrite;
		logic [31:0] memAddr;
		logic [31:0] memData;
	} memAccess_t;

	typedef struct packed {
		regWrite_t   regWrite;
		memAccess_t  mem;
		logic [31:0] nextPc;
	} execResult_t;

endpackage

`default_nettype wire

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
	input  logic [5:0]        op,
	input  logic [5:0]        fn,
	output cpuPkg::ctrlWord_t ctrl
);
	import cpuPkg::*;

	always_comb begin
		// Unlisted codes fall through as a no-op
		ctrl = '0;
		casez ({op, fn})
			// Arithmetic
			12'b000000_000001: begin
				ctrl.writeEn = 1'b1;
				ctrl.regInData = fromAlu;
			end
			12'b000000_000010: begin
				ctrl.writeEn = 1'b1;
				ctrl.aluFn = 1'b1;
				ctrl.regInData = fromAlu;
			end
			12'b000001_??????: begin
				ctrl.writeEn = 1'b1;
				ctrl.aluImm = 1'b1;
				ctrl.regInData = fromAlu;
			end
			12'b000010_??????: begin
				ctrl.writeEn = 1'b1;
				ctrl.aluImm = 1'b1;
				ctrl.aluFn = 1'b1;
				ctrl.regInData = fromAlu;
			end
			// Logic
			12'b100000_000001, 12'b100000_000010: begin
				ctrl.writeEn = 1'b1;
				ctrl.fnClass = 1'b1;
				ctrl.logicFn = fn[1];
				ctrl.regInData = fromAlu;
			end
			//////////////////////////////////////////////////////////////
			// Shifter
			//////////////////////////////////////////////////////////////
			// fn[0] selects a register amount
			12'b110000_000000, 12'b110000_000001: begin
				ctrl.writeEn = 1'b1;
				ctrl.regImm = fn[0];
				ctrl.shiftLogical = 1'b1;
				ctrl.shiftLeft = 1'b1;
				ctrl.regInData = fromShift;
			end
			12'b110000_100000, 12'b110000_100001: begin
				ctrl.writeEn = 1'b1;
				ctrl.regImm = fn[0];
				ctrl.shiftLogical = 1'b1;
				ctrl.regInData = fromShift;
			end
			// Arithmetic right shifts
			12'b110000_100010, 12'b110000_100011: begin
				ctrl.writeEn = 1'b1;
				ctrl.regImm = fn[0];
				ctrl.regInData = fromShift;
			end
			// Load and store
			12'b110100_??????: begin
				ctrl.writeEn = 1'b1;
				ctrl.aluImm = 1'b1;
				ctrl.dataRead = 1'b1;
				ctrl.regInData = fromMem;
			end
			12'b110101_??????: begin
				ctrl.aluImm = 1'b1;
				ctrl.dataWrite = 1'b1;
			end
			//////////////////////////////////////////////////////////////
			// Control transfer
			//////////////////////////////////////////////////////////////
			12'b010001_??????: ctrl.pcSel = pcJump;
			12'b010000_000001, 12'b010000_000010: ctrl.pcSel = pcReg;
			12'b010010_??????: begin
				ctrl.brType = 3'b100;
				ctrl.pcSel = pcBranch;
			end
			12'b010011_??????: begin
				ctrl.brType = 3'b000;
				ctrl.pcSel = pcBranch;
			end
			12'b010100_??????: begin
				ctrl.brType = 3'b101;
				ctrl.pcSel = pcBranch;
			end
			12'b010101_??????: begin
				ctrl.brType = 3'b001;
				ctrl.pcSel = pcBranch;
			end
			12'b010110_??????: begin
				ctrl.brType = 3'b110;
				ctrl.pcSel = pcBranch;
			end
			12'b010111_??????: begin
				ctrl.brType = 3'b010;
				ctrl.pcSel = pcBranch;
			end
			12'b011000_??????: begin
				ctrl.brType = 3'b111;
				ctrl.pcSel = pcBranch;
			end
			12'b011001_??????: begin
				ctrl.brType = 3'b011;
				ctrl.pcSel = pcBranch;
			end
			// Jump and link into r31
			12'b011010_??????: begin
				ctrl.regDst = destLink;
				ctrl.writeEn = 1'b1;
				ctrl.pcSel = pcJump;
				ctrl.regInData = fromLink;
			end
			default: ctrl = '0;
		endcase
	end

	// A memory access is either a read or a write over the whole table
	always_comb begin
		assert final (!(ctrl.dataRead && ctrl.dataWrite))
			else $error("decoder set dataRead and dataWrite for op %h fn %h", op, fn);
	end

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile (
	input  logic              clk,
	input  logic              rst,
	input  logic [4:0]        rsAddr,
	input  logic [4:0]        rtAddr,
	output logic [31:0]       rsValue,
	output logic [31:0]       rtValue,
	input  cpuPkg::regWrite_t regWrite
);

	logic [31:0] regs [32];

	// Write port never touches r0
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int idx = 0; idx < 32; idx++) begin
				regs[idx] <= '0;
			end
		end else if (regWrite.writeEn && (regWrite.writeReg != 5'd0)) begin
			regs[regWrite.writeReg] <= regWrite.writeData;
		end
	end

	// Combinational read ports
	always_comb begin
		if (rsAddr == 5'd0) begin
			rsValue = '0;
		end else begin
			rsValue = regs[rsAddr];
		end
	end

	always_comb begin
		if (rtAddr == 5'd0) begin
			rtValue = '0;
		end else begin
			rtValue = regs[rtAddr];
		end
	end

endmodule

`default_nettype wire

// ==== source/aluUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
	input  cpuPkg::ctrlWord_t ctrl,
	input  logic [31:0]       rsValue,
	input  logic [31:0]       rtValue,
	input  logic [15:0]       imm,
	output logic [31:0]       aluResult
);

	logic [31:0] immExt;
	logic [31:0] operandB;
	logic [31:0] arithResult;
	logic [31:0] logicResult;

	// Sign extended immediate
	assign immExt = {{16{imm[15]}}, imm};

	assign operandB = ctrl.aluImm ? immExt : rtValue;

	always_comb begin
		if (ctrl.aluFn) begin
			arithResult = rsValue - operandB;
		end else begin
			arithResult = rsValue + operandB;
		end
	end

	always_comb begin
		if (ctrl.logicFn) begin
			logicResult = rsValue | operandB;
		end else begin
			logicResult = rsValue & operandB;
		end
	end

	// fnClass picks between the two halves
	always_comb begin
		if (ctrl.fnClass) begin
			aluResult = logicResult;
		end else begin
			aluResult = arithResult;
		end
	end

endmodule

`default_nettype wire

// ==== source/shiftUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module shiftUnit (
	input  cpuPkg::ctrlWord_t ctrl,
	input  logic [31:0]       rsValue,
	input  logic [31:0]       rtValue,
	input  logic [4:0]        shamt,
	output logic [31:0]       shiftResult
);

	logic [4:0] amount;

	// Amount from instruction field or from rt
	always_comb begin
		if (ctrl.regImm) begin
			amount = rtValue[4:0];
		end else begin
			amount = shamt;
		end
	end

	always_comb begin
		if (ctrl.shiftLeft) begin
			shiftResult = rsValue << amount;
		end else if (ctrl.shiftLogical) begin
			shiftResult = rsValue >> amount;
		end else begin
			// Sign bit fills from the left
			shiftResult = $signed(rsValue) >>> amount;
		end
	end

endmodule

`default_nettype wire

// ==== source/writebackMerge.sv ====
`timescale 1ns/1ns
`default_nettype none

module writebackMerge (
	input  cpuPkg::ctrlWord_t  ctrl,
	input  cpuPkg::instrWord_t instr,
	input  logic [31:0]        rsValue,
	input  logic [31:0]        rtValue,
	input  logic [31:0]        aluResult,
	input  logic [31:0]        shiftResult,
	input  logic [31:0]        pc,
	output cpuPkg::regWrite_t  regWrite,
	output cpuPkg::memAccess_t mem,
	output logic [31:0]        nextPc
);
	import cpuPkg::*;

	logic [31:0] pcPlusOne;
	logic [31:0] branchTarget;
	logic        condBase;
	logic        branchTaken;
	logic        writeEn;

	assign pcPlusOne = pc + 32'd1;
	assign branchTarget = pcPlusOne + {{16{instr.i.imm[15]}}, instr.i.imm};

	//////////////////////////////////////////////////////////////////////
	// Write back
	//////////////////////////////////////////////////////////////////////

	// No load data comes back, so a load never writes
	assign writeEn = ctrl.writeEn && (ctrl.regInData != fromMem);

	always_comb begin
		regWrite = '0;
		if (writeEn) begin
			regWrite.writeEn = 1'b1;
			regWrite.writeReg = (ctrl.regDst == destLink) ? 5'd31 : instr.i.rd;
			case (ctrl.regInData)
				fromAlu:   regWrite.writeData = aluResult;
				fromShift: regWrite.writeData = shiftResult;
				fromLink:  regWrite.writeData = pcPlusOne;
				default:   regWrite.writeData = '0;
			endcase
		end
	end

	// On a store rtValue already holds rd
	always_comb begin
		mem = '0;
		if (ctrl.dataRead || ctrl.dataWrite) begin
			mem.memRead = ctrl.dataRead;
			mem.memWrite = ctrl.dataWrite;
			mem.memAddr = aluResult;
			mem.memData = ctrl.dataWrite ? rtValue : '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Next pc
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (ctrl.brType[1:0])
			2'b00:   condBase = (rsValue == '0);
			2'b01:   condBase = rsValue[31];
			2'b10:   condBase = !rsValue[31] && (rsValue != '0);
			default: condBase = !rsValue[31];
		endcase
	end

	assign branchTaken = condBase ^ ctrl.brType[2];

	always_comb begin
		case (ctrl.pcSel)
			pcJump:   nextPc = {6'd0, instr.j.target};
			pcBranch: nextPc = branchTaken ? branchTarget : pcPlusOne;
			pcReg:    nextPc = rsValue;
			default:  nextPc = pcPlusOne;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/execCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module execCore #(
	parameter logic [31:0] resetPc = 32'd0
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                instrReq,
	input  cpuPkg::instrWord_t  instr,
	output logic                instrAck,
	output cpuPkg::execResult_t result
);
	import cpuPkg::*;

	typedef enum logic [1:0] {stIdle, stExecute, stAck} seqState_e;

	seqState_e   state;
	instrWord_t  instrReg;
	ctrlWord_t   ctrl;
	logic [4:0]  rtAddr;
	logic [31:0] rsValue;
	logic [31:0] rtValue;
	logic [31:0] aluResult;
	logic [31:0] shiftResult;
	logic [31:0] pc;
	logic [31:0] nextPc;
	regWrite_t   mergeWrite;
	regWrite_t   regWrite;
	memAccess_t  mem;

	//////////////////////////////////////////////////////////////////////
	// Handshake sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			instrAck <= 1'b0;
			instrReg <= '0;
			pc <= resetPc;
			result <= '0;
		end else begin
			case (state)
				stIdle: begin
					if (instrReq) begin
						instrReg <= instr;
						state <= stExecute;
					end
				end
				stExecute: begin
					pc <= nextPc;
					result <= '{regWrite: mergeWrite, mem: mem, nextPc: nextPc};
					instrAck <= 1'b1;
					state <= stAck;
				end
				stAck: begin
					// Hold ack and result until req drops
					if (!instrReq) begin
						instrAck <= 1'b0;
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Only the execute cycle writes the register file
	always_comb begin
		regWrite = mergeWrite;
		regWrite.writeEn = mergeWrite.writeEn && (state == stExecute);
	end

	// Stores read rd through the rt port
	assign rtAddr = ctrl.dataWrite ? instrReg.i.rd : instrReg.r.rt;

	instrDecoder decoder (.op(instrReg.r.op), .fn(instrReg.r.fn), .ctrl(ctrl));

	regFile regs (
		.clk(clk), .rst(rst), .rsAddr(instrReg.r.rs), .rtAddr(rtAddr),
		.rsValue(rsValue), .rtValue(rtValue), .regWrite(regWrite)
	);

	aluUnit alu (
		.ctrl(ctrl), .rsValue(rsValue), .rtValue(rtValue),
		.imm(instrReg.i.imm), .aluResult(aluResult)
	);

	shiftUnit shifter (
		.ctrl(ctrl), .rsValue(rsValue), .rtValue(rtValue),
		.shamt(instrReg.r.shamt), .shiftResult(shiftResult)
	);

	writebackMerge merge (
		.ctrl(ctrl), .instr(instrReg), .rsValue(rsValue), .rtValue(rtValue),
		.aluResult(aluResult), .shiftResult(shiftResult), .pc(pc),
		.regWrite(mergeWrite), .mem(mem), .nextPc(nextPc)
	);

	// Ack is only set on an edge that still sees the request
	ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
		$rose(instrAck) |-> $past(instrReq));

endmodule

`default_nettype wire

// ==== dv/execCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module execCoreTb;
	import cpuPkg::*;

	localparam int maxTests = 64;
	localparam int wordsPerTest = 9;
	localparam int handshakeLimit = 10;

	logic        clk;
	logic        rst;
	logic        instrReq;
	instrWord_t  instr;
	logic        instrAck;
	execResult_t result;

	// Word 0 is the test count, then nine words per test
	logic [31:0] testMem [1 + wordsPerTest * maxTests];
	int          numTests;
	int          cycleLimit = 0;
	int          cycleCount = 0;
	int          passCount = 0;
	int          failCount = 0;

	execCore #(.resetPc(32'd0)) DUT (
		.clk(clk), .rst(rst), .instrReq(instrReq), .instr(instr),
		.instrAck(instrAck), .result(result)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Run stopped at cycle %0d before all tests finished", cycleCount);
			$display("sim failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	function automatic int compareField(input string tag, input string name,
			input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s %s got %h expected %h", tag, name, got, exp);
			return 1;
		end
		return 0;
	endfunction

	task automatic checkWrite(input string tag, input regWrite_t got, input regWrite_t exp,
			inout int errs);
		errs += compareField(tag, "writeEn", got.writeEn, exp.writeEn);
		errs += compareField(tag, "writeReg", got.writeReg, exp.writeReg);
		errs += compareField(tag, "writeData", got.writeData, exp.writeData);
	endtask

	task automatic checkMem(input string tag, input memAccess_t got, input memAccess_t exp,
			inout int errs);
		errs += compareField(tag, "memRead", got.memRead, exp.memRead);
		errs += compareField(tag, "memWrite", got.memWrite, exp.memWrite);
		errs += compareField(tag, "memAddr", got.memAddr, exp.memAddr);
		errs += compareField(tag, "memData", got.memData, exp.memData);
	endtask

	task automatic checkPc(input string tag, input logic [31:0] got, input logic [31:0] exp,
			inout int errs);
		errs += compareField(tag, "nextPc", got, exp);
	endtask

	task automatic recordTest(input string tag, input int errs);
		if (errs == 0) begin
			passCount++;
			$display("%s: ok", tag);
		end else begin
			failCount++;
			$display("%s: %0d mismatches", tag, errs);
		end
	endtask

	// Four-phase handshake started 1 ns after a rising edge
	task automatic driveInstr(input instrWord_t word, output execResult_t got,
			output bit ackSeen, output bit ackDropped);
		int waitCycles;
		got = '0;
		ackSeen = 1'b0;
		instr = word;
		instrReq = 1'b1;
		waitCycles = 0;
		while (!instrAck && waitCycles < handshakeLimit) begin
			@(posedge clk);
			#1;
			waitCycles++;
		end
		if (instrAck) begin
			ackSeen = 1'b1;
			got = result;
		end
		instrReq = 1'b0;
		waitCycles = 0;
		while (instrAck && waitCycles < handshakeLimit) begin
			@(posedge clk);
			#1;
			waitCycles++;
		end
		ackDropped = !instrAck;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		instrWord_t  word;
		execResult_t got;
		execResult_t exp;
		bit          ackSeen;
		bit          ackDropped;
		bit          stopRun;
		int          testIdx;
		int          base;
		int          errs;
		string       tag;

		rst = 1'b1;
		instrReq = 1'b0;
		instr = '0;
		stopRun = 1'b0;
		$readmemh("dv/execTests.txt", testMem);
		numTests = testMem[0];
		cycleLimit = 20 * numTests + 50;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		// Idle outputs after reset
		errs = compareField("reset", "instrAck", instrAck, 1'b0);
		checkWrite("reset", result.regWrite, '0, errs);
		checkMem("reset", result.mem, '0, errs);
		checkPc("reset", result.nextPc, 32'd0, errs);
		recordTest("reset", errs);

		if (numTests < 1 || numTests > maxTests) begin
			$display("Test file gives %0d tests, outside 1 to %0d", numTests, maxTests);
			failCount++;
			stopRun = 1'b1;
		end

		for (testIdx = 0; testIdx < numTests && !stopRun; testIdx++) begin
			base = 1 + wordsPerTest * testIdx;
			word = testMem[base];
			exp.regWrite.writeEn = testMem[base + 1][0];
			exp.regWrite.writeReg = testMem[base + 2][4:0];
			exp.regWrite.writeData = testMem[base + 3];
			exp.mem.memRead = testMem[base + 4][0];
			exp.mem.memWrite = testMem[base + 5][0];
			exp.mem.memAddr = testMem[base + 6];
			exp.mem.memData = testMem[base + 7];
			exp.nextPc = testMem[base + 8];
			tag = $sformatf("test %0d instr %h", testIdx, word);
			driveInstr(word, got, ackSeen, ackDropped);
			errs = 0;
			if (!ackSeen) begin
				$display("%s: no acknowledge within %0d cycles", tag, handshakeLimit);
				errs++;
				stopRun = 1'b1;
			end else begin
				checkWrite(tag, got.regWrite, exp.regWrite, errs);
				checkMem(tag, got.mem, exp.mem, errs);
				checkPc(tag, got.nextPc, exp.nextPc, errs);
				if (!ackDropped) begin
					$display("%s: acknowledge stayed high after the request dropped", tag);
					errs++;
					stopRun = 1'b1;
				end
			end
			recordTest(tag, errs);
		end

		$display("Tests run %0d, ok %0d, failed %0d", passCount + failCount, passCount,
			failCount);
		if (failCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/execTests.txt ====
// instr wrEn wrReg wrData memRd memWr memAddr memData nextPc
// First word is the number of tests that follow
1F
// Immediate arithmetic
04200064 1 01 00000064 0 0 00000000 00000000 00000001
0440FFFB 1 02 FFFFFFFB 0 0 00000000 00000000 00000002
08610030 1 03 00000034 0 0 00000000 00000000 00000003
04800F0F 1 04 00000F0F 0 0 00000000 00000000 00000004
// Register add, subtract, AND, OR
00A11001 1 05 0000005F 0 0 00000000 00000000 00000005
00C30802 1 06 FFFFFFD0 0 0 00000000 00000000 00000006
80E40801 1 07 00000004 0 0 00000000 00000000 00000007
81041002 1 08 FFFFFFFF 0 0 00000000 00000000 00000008
// Shifts
C1240100 1 09 0000F0F0 0 0 00000000 00000000 00000009
C1413801 1 0A 00000640 0 0 00000000 00000000 0000000A
C1620220 1 0B 00FFFFFF 0 0 00000000 00000000 0000000B
C1863821 1 0C 0FFFFFFD 0 0 00000000 00000000 0000000C
C1A20062 1 0D FFFFFFFD 0 0 00000000 00000000 0000000D
C1C63823 1 0E FFFFFFFD 0 0 00000000 00000000 0000000E
C1E40222 1 0F 0000000F 0 0 00000000 00000000 0000000F
// Load and store
D0A10010 0 00 00000000 1 0 00000074 00000000 00000010
D523FFFC 0 00 00000000 0 1 00000030 0000F0F0 00000011
// Branches
4C000003 0 00 00000000 0 0 00000000 00000000 00000015
48000005 0 00 00000000 0 0 00000000 00000000 00000016
54010002 0 00 00000000 0 0 00000000 00000000 00000017
50010004 0 00 00000000 0 0 00000000 00000000 0000001C
5C010010 0 00 00000000 0 0 00000000 00000000 0000002D
58010007 0 00 00000000 0 0 00000000 00000000 0000002E
6402FFF0 0 00 00000000 0 0 00000000 00000000 0000002F
6002FFF0 0 00 00000000 0 0 00000000 00000000 00000020
// Jump, jump register, jump and link
44000100 0 00 00000000 0 0 00000000 00000000 00000100
40010001 0 00 00000000 0 0 00000000 00000000 00000064
68000200 1 1F 00000065 0 0 00000000 00000000 00000200
// Undefined opcode, then r0 write and read back
FC4A1234 0 00 00000000 0 0 00000000 00000000 00000201
04000055 1 00 00000055 0 0 00000000 00000000 00000202
02000001 1 10 00000000 0 0 00000000 00000000 00000203

// ==== vlog.f ====
source/cpuPkg.sv
source/instrDecoder.sv
source/regFile.sv
source/aluUnit.sv
source/shiftUnit.sv
source/writebackMerge.sv
source/execCore.sv
dv/execCoreTb.sv
